// ==== src/eth_rx_macros.svh ====
// Ethernet receive constants fixed by the standard, shared by the packages and RTL
`ifndef ETH_RX_MACROS_SVH
`define ETH_RX_MACROS_SVH

// Preamble and start-of-frame delimiter bytes as seen on the byte interface
`define ETH_PREAMBLE_BYTE 8'h55
`define ETH_SFD_BYTE      8'hD5

// Destination, source and type/length
`define ETH_HDR_BYTES 14

// Frame size limits, FCS included, preamble and SFD excluded
`define ETH_MIN_FRAME 64
`define ETH_MAX_FRAME 1518

// Largest type/length value that still means a payload length
`define ETH_MAX_LENGTH 1500

// CRC-32 remainder over a good frame plus its FCS, normal bit order
`define ETH_CRC_RESIDUE 32'hC704DD7B

`define ETH_COUNT_BITS 11

`endif

// ==== src/eth_frame_pkg.sv ====
// Ethernet frame field types for the header and the byte position
`include "eth_rx_macros.svh"

package eth_frame_pkg;

    // Station address, first byte on the wire in the top bits
    typedef logic [47:0] mac_addr_t;

    // Protocol number, meaningful from 1536 upward
    typedef logic [15:0] ethertype_t;

    // Payload length, meaningful up to 1500
    typedef logic [15:0] length_t;

    // The same header word read either way; the value range picks the meaning
    typedef union packed {
        ethertype_t ethertype;
        length_t    length;
    } type_len_u;

    // Byte position within a frame, wide enough for a saturated giant
    typedef logic [`ETH_COUNT_BITS-1:0] frame_count_t;

endpackage

// ==== src/eth_rx_status_pkg.sv ====
// Receive state and frame status encodings
package eth_rx_status_pkg;

    // Where the receiver is within a frame
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        HEADER  = 2'd1,
        PAYLOAD = 2'd2,
        DROP    = 2'd3
    } rx_state_e;

    // Result reported with frame_done
    // Priority when several apply is GIANT, then RUNT, then CRC_ERR
    typedef enum logic [1:0] {
        STATUS_OK      = 2'd0,
        STATUS_CRC_ERR = 2'd1,
        STATUS_RUNT    = 2'd2,
        STATUS_GIANT   = 2'd3
    } frame_status_e;

endpackage

// ==== src/eth_preamble_detector.sv ====
// Preamble run and SFD detector with outputs three cycles behind the sampled byte
`include "eth_rx_macros.svh"

module eth_preamble_detector (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] rx_data,
    input  logic       rx_dv,
    output logic       preamble_detected,
    output logic       sfd_detected
);
    localparam logic [2:0] RUN_MAX     = 3'd7;
    // Two earlier preamble bytes make the current one the third
    localparam logic [2:0] PRE_RUN_MIN = 3'd2;
    localparam logic [2:0] SFD_RUN_MIN = 3'd6;

    logic [7:0] data_q;
    logic       dv_q;
    logic       data_is_preamble;
    logic       data_is_sfd;
    logic [2:0] run_count;
    logic [2:0] run_at_match;
    logic       pre_match;
    logic       sfd_match;
    logic       pre_valid;
    logic       sfd_valid;

    assign data_is_preamble = dv_q && (data_q == `ETH_PREAMBLE_BYTE);
    assign data_is_sfd      = dv_q && (data_q == `ETH_SFD_BYTE);

    // Input sample
    always_ff @(posedge clk) begin
        data_q <= rx_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dv_q <= 1'b0;
        end else begin
            dv_q <= rx_dv;
        end
    end

    // Consecutive preamble bytes, saturating; any other byte restarts the run
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            run_count <= '0;
        end else if (!data_is_preamble) begin
            run_count <= '0;
        end else if (run_count != RUN_MAX) begin
            run_count <= run_count + 3'd1;
        end
    end

    // Match stage, run length taken before the current byte is counted
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pre_match    <= 1'b0;
            sfd_match    <= 1'b0;
            run_at_match <= '0;
        end else begin
            pre_match    <= data_is_preamble;
            sfd_match    <= data_is_sfd;
            run_at_match <= run_count;
        end
    end

    // Validation stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pre_valid <= 1'b0;
            sfd_valid <= 1'b0;
        end else begin
            pre_valid <= pre_match && (run_at_match >= PRE_RUN_MIN);
            sfd_valid <= sfd_match && (run_at_match >= SFD_RUN_MIN);
        end
    end

    // Outputs drop at once when the line goes idle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            preamble_detected <= 1'b0;
            sfd_detected      <= 1'b0;
        end else if (!rx_dv) begin
            preamble_detected <= 1'b0;
            sfd_detected      <= 1'b0;
        end else begin
            preamble_detected <= pre_valid;
            sfd_detected      <= sfd_valid;
        end
    end

endmodule

// ==== src/eth_rx_fsm.sv ====
// Receive FSM with byte alignment, frame framing and end-of-frame classification
`include "eth_rx_macros.svh"

module eth_rx_fsm (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [7:0]                       rx_data,
    input  logic                             rx_dv,
    input  logic                             sfd_detected,
    input  eth_frame_pkg::frame_count_t      byte_count,
    input  logic                             crc_ok,
    output logic [7:0]                       byte_data,
    output logic                             byte_valid,
    output logic                             frame_start,
    output logic                             frame_end,
    output logic                             frame_done,
    output eth_rx_status_pkg::frame_status_e frame_status,
    output eth_frame_pkg::frame_count_t      frame_length,
    output eth_rx_status_pkg::rx_state_e     state
);
    import eth_frame_pkg::*;
    import eth_rx_status_pkg::*;

    // Matches the detector latency so the first frame byte lines up with sfd_detected
    localparam int ALIGN_STAGES = 3;

    logic [7:0]              data_pipe [ALIGN_STAGES];
    logic [ALIGN_STAGES-1:0] dv_pipe;
    logic                    aligned_dv;
    rx_state_e               state_next;
    logic                    end_seen;
    frame_count_t            end_count;
    logic                    end_crc_ok;
    logic                    end_dropped;
    frame_status_e           status_next;

    always_ff @(posedge clk) begin
        data_pipe[0] <= rx_data;
        for (int i = 1; i < ALIGN_STAGES; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dv_pipe <= '0;
        end else begin
            dv_pipe <= {dv_pipe[ALIGN_STAGES-2:0], rx_dv};
        end
    end

    assign aligned_dv  = dv_pipe[ALIGN_STAGES-1];
    assign byte_data   = data_pipe[ALIGN_STAGES-1];
    // SFD outside IDLE is ignored
    assign frame_start = (state == IDLE) && sfd_detected && aligned_dv;
    assign frame_end   = (state != IDLE) && !aligned_dv;
    assign byte_valid  = aligned_dv && (frame_start || (state != IDLE));

    // byte_count equals the index of the byte on byte_data once past frame_start
    always_comb begin
        state_next = state;
        unique case (state)
            IDLE:    if (frame_start) state_next = HEADER;
            HEADER:  if (!aligned_dv) state_next = IDLE;
                     else if (byte_count == `ETH_HDR_BYTES - 1) state_next = PAYLOAD;
            PAYLOAD: if (!aligned_dv) state_next = IDLE;
                     else if (byte_count >= `ETH_MAX_FRAME) state_next = DROP;
            DROP:    if (!aligned_dv) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state    <= IDLE;
            end_seen <= 1'b0;
        end else begin
            state    <= state_next;
            end_seen <= frame_end;
        end
    end

    // Snapshot of the finished frame
    always_ff @(posedge clk) begin
        if (frame_end) begin
            end_count   <= byte_count;
            end_crc_ok  <= crc_ok;
            end_dropped <= (state == DROP);
        end
    end

    always_comb begin
        if (end_dropped) begin
            status_next = STATUS_GIANT;
        end else if (end_count < `ETH_MIN_FRAME) begin
            status_next = STATUS_RUNT;
        end else if (!end_crc_ok) begin
            status_next = STATUS_CRC_ERR;
        end else begin
            status_next = STATUS_OK;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_done   <= 1'b0;
            frame_status <= STATUS_OK;
            frame_length <= '0;
        end else begin
            frame_done <= end_seen;
            if (end_seen) begin
                frame_status <= status_next;
                frame_length <= end_count;
            end
        end
    end

endmodule

// ==== src/eth_byte_counter.sv ====
// Saturating frame byte counter, the position reference for the receive path
module eth_byte_counter (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        frame_start,
    input  logic                        byte_valid,
    output eth_frame_pkg::frame_count_t byte_count
);
    import eth_frame_pkg::*;

    localparam frame_count_t COUNT_MAX = '1;

    // frame_start comes with byte 0, so the count leaves it at 1
    // and then equals the index of the byte being presented
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            byte_count <= '0;
        end else if (frame_start) begin
            byte_count <= frame_count_t'(1);
        end else if (byte_valid && (byte_count != COUNT_MAX)) begin
            byte_count <= byte_count + frame_count_t'(1);
        end
    end

endmodule

// ==== src/eth_header_parser.sv ====
// Header parser capturing the addresses and the type/length word by byte index
`include "eth_rx_macros.svh"

module eth_header_parser (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [7:0]                  byte_data,
    input  logic                        byte_valid,
    input  eth_frame_pkg::frame_count_t byte_count,
    output eth_frame_pkg::mac_addr_t    dest_mac,
    output eth_frame_pkg::mac_addr_t    src_mac,
    output eth_frame_pkg::type_len_u    type_len,
    output logic                        len_is_length
);
    import eth_frame_pkg::*;

    localparam int DEST_END = 6;
    localparam int SRC_END  = 12;

    logic [7:0]   data_q;
    logic         valid_q;
    frame_count_t index;

    // Byte is held one cycle, by then the counter has moved past it
    assign index = byte_count - frame_count_t'(1);

    always_ff @(posedge clk) begin
        data_q <= byte_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= byte_valid;
        end
    end

    // First byte on the wire ends up in the top bits
    always_ff @(posedge clk) begin
        if (valid_q) begin
            if (index < DEST_END) begin
                dest_mac <= {dest_mac[39:0], data_q};
            end else if (index < SRC_END) begin
                src_mac <= {src_mac[39:0], data_q};
            end else if (index < `ETH_HDR_BYTES) begin
                type_len <= {type_len.ethertype[7:0], data_q};
            end
        end
    end

    // Values from 1501 to 1535 are undefined and read as a type
    assign len_is_length = (type_len.length <= `ETH_MAX_LENGTH);

endmodule

// ==== src/eth_crc32_checker.sv ====
// Byte-wise reflected CRC-32 over the frame and FCS with a residue check
`include "eth_rx_macros.svh"

module eth_crc32_checker (
    input  logic       clk,
    input  logic       reset,
    input  logic       frame_start,
    input  logic [7:0] byte_data,
    input  logic       byte_valid,
    output logic       crc_ok
);
    localparam logic [31:0] CRC_POLY = 32'hEDB88320;
    localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;
    // Register shifts LSB first, so it holds the residue bit-reversed
    localparam logic [31:0] RESIDUE_REFLECTED = {<<{`ETH_CRC_RESIDUE}};

    logic [31:0] crc_q;
    logic [31:0] crc_seed;
    logic [31:0] crc_next;

    function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in,
                                               input logic [7:0]  data);
        logic [31:0] c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    // Byte 0 arrives with frame_start and is folded into a fresh seed
    assign crc_seed = frame_start ? CRC_INIT : crc_q;
    assign crc_next = crc32_byte(crc_seed, byte_data);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            crc_q <= CRC_INIT;
        end else if (byte_valid) begin
            crc_q <= crc_next;
        end
    end

    assign crc_ok = (crc_q == RESIDUE_REFLECTED);

endmodule

// ==== src/eth_rx_top.sv ====
// Ethernet MAC receive front end on the GMII byte interface
module eth_rx_top (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [7:0]                       rx_data,
    input  logic                             rx_dv,
    output logic                             preamble_detected,
    output logic                             frame_done,
    output eth_rx_status_pkg::frame_status_e frame_status,
    output eth_frame_pkg::frame_count_t      frame_length,
    output eth_frame_pkg::mac_addr_t         dest_mac,
    output eth_frame_pkg::mac_addr_t         src_mac,
    output eth_frame_pkg::type_len_u         type_len,
    output logic                             len_is_length,
    output eth_rx_status_pkg::rx_state_e     rx_state
);
    import eth_frame_pkg::*;

    logic         sfd_detected;
    logic [7:0]   byte_data;
    logic         byte_valid;
    logic         frame_start;
    logic         crc_ok;
    frame_count_t byte_count;

    eth_preamble_detector u_preamble (
        .clk               (clk),
        .reset             (reset),
        .rx_data           (rx_data),
        .rx_dv             (rx_dv),
        .preamble_detected (preamble_detected),
        .sfd_detected      (sfd_detected)
    );

    eth_rx_fsm u_fsm (
        .clk          (clk),
        .reset        (reset),
        .rx_data      (rx_data),
        .rx_dv        (rx_dv),
        .sfd_detected (sfd_detected),
        .byte_count   (byte_count),
        .crc_ok       (crc_ok),
        .byte_data    (byte_data),
        .byte_valid   (byte_valid),
        .frame_start  (frame_start),
        .frame_end    (),
        .frame_done   (frame_done),
        .frame_status (frame_status),
        .frame_length (frame_length),
        .state        (rx_state)
    );

    eth_byte_counter u_counter (
        .clk         (clk),
        .reset       (reset),
        .frame_start (frame_start),
        .byte_valid  (byte_valid),
        .byte_count  (byte_count)
    );

    eth_header_parser u_parser (
        .clk           (clk),
        .reset         (reset),
        .byte_data     (byte_data),
        .byte_valid    (byte_valid),
        .byte_count    (byte_count),
        .dest_mac      (dest_mac),
        .src_mac       (src_mac),
        .type_len      (type_len),
        .len_is_length (len_is_length)
    );

    eth_crc32_checker u_crc (
        .clk         (clk),
        .reset       (reset),
        .frame_start (frame_start),
        .byte_data   (byte_data),
        .byte_valid  (byte_valid),
        .crc_ok      (crc_ok)
    );

endmodule

// ==== tb/eth_rx_tb.sv ====
// Testbench for the Ethernet receive front end with frame generation and assertion checks
`include "eth_rx_macros.svh"

module eth_rx_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import eth_frame_pkg::*;
    import eth_rx_status_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int GAP_CYCLES   = 12;
    localparam int NUM_FRAMES   = 8;
    // Largest byte count of every frame sent below with the random frame at its upper bound
    localparam int TEST_BYTES   = 64 + 1518 + 80 + 128 + 40 + 1530 + 64 + 72;
    // Preamble, SFD and idle gap per frame
    localparam int FRAME_EXTRA  = 8 + GAP_CYCLES;
    localparam int WATCHDOG_CYCLES =
        RESET_CYCLES + TEST_BYTES + NUM_FRAMES * FRAME_EXTRA + 200;

    typedef struct {
        string         name;
        mac_addr_t     dest;
        mac_addr_t     src;
        logic [15:0]   type_len;
        logic          is_length;
        frame_count_t  length;
        frame_status_e status;
    } expect_t;

    logic             clk;
    logic             reset;
    logic [7:0]       rx_data;
    logic             rx_dv;
    logic             preamble_detected;
    logic             frame_done;
    frame_status_e    frame_status;
    frame_count_t     frame_length;
    mac_addr_t        dest_mac;
    mac_addr_t        src_mac;
    type_len_u        type_len;
    logic             len_is_length;
    rx_state_e        rx_state;

    expect_t          exp_q [$];
    logic             exp_valid = 1'b0;
    string            exp_name = "none";
    mac_addr_t        exp_dest = '0;
    mac_addr_t        exp_src = '0;
    logic [15:0]      exp_type_len = '0;
    logic             exp_is_length = 1'b0;
    frame_count_t     exp_length = '0;
    frame_status_e    exp_status = STATUS_OK;
    logic             done_prev = 1'b0;
    int               errors = 0;
    int               frames_expected = 0;
    int               frames_checked = 0;

    eth_rx_top dut0 (
        .clk               (clk),
        .reset             (reset),
        .rx_data           (rx_data),
        .rx_dv             (rx_dv),
        .preamble_detected (preamble_detected),
        .frame_done        (frame_done),
        .frame_status      (frame_status),
        .frame_length      (frame_length),
        .dest_mac          (dest_mac),
        .src_mac           (src_mac),
        .type_len          (type_len),
        .len_is_length     (len_is_length),
        .rx_state          (rx_state)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string field, input logic [63:0] expected,
                                   input logic [63:0] actual);
        errors++;
        $display("Mismatch %s %s: expected 0x%0h, actual 0x%0h",
                 exp_name, field, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error at %0d ns: %s", $time, what);
    endtask

    // Reflected Ethernet CRC-32 with the register left uninverted
    function automatic logic [31:0] crc32_ref(input logic [7:0] data [], input int len);
        logic [31:0] crc;
        crc = 32'hFFFFFFFF;
        for (int i = 0; i < len; i++) begin
            crc = crc ^ {24'h0, data[i]};
            repeat (8) begin
                crc = (crc >> 1) ^ (32'hEDB88320 & {32{crc[0]}});
            end
        end
        return crc;
    endfunction

    task automatic drive_byte(input logic [7:0] value);
        @(posedge clk);
        rx_dv   <= 1'b1;
        rx_data <= value;
    endtask

    task automatic send_frame(input string name, input int pre_len, input int n_bytes,
                              input logic [15:0] tl, input bit corrupt);
        logic [7:0]  bytes [];
        logic [31:0] fcs;
        expect_t     entry;
        bytes = new[n_bytes];
        for (int i = 0; i < 12; i++) begin
            bytes[i] = 8'($urandom);
        end
        bytes[12] = tl[15:8];
        bytes[13] = tl[7:0];
        for (int i = `ETH_HDR_BYTES; i < n_bytes - 4; i++) begin
            bytes[i] = 8'($urandom);
        end
        fcs = ~crc32_ref(bytes, n_bytes - 4);
        // FCS goes out least significant byte first
        for (int i = 0; i < 4; i++) begin
            bytes[n_bytes - 4 + i] = fcs[8*i +: 8];
        end
        if (corrupt) begin
            bytes[20][3] = ~bytes[20][3];
        end

        // Only a run of six or more preamble bytes starts a frame
        if (pre_len >= 6) begin
            entry.name = name;
            entry.dest = '0;
            entry.src  = '0;
            for (int i = 0; i < 6; i++) begin
                entry.dest = {entry.dest[39:0], bytes[i]};
                entry.src  = {entry.src[39:0], bytes[i + 6]};
            end
            entry.type_len  = tl;
            entry.is_length = (tl <= 16'(`ETH_MAX_LENGTH));
            entry.length    = (n_bytes > 2047) ? 11'd2047 : 11'(n_bytes);
            if (n_bytes > `ETH_MAX_FRAME) begin
                entry.status = STATUS_GIANT;
            end else if (n_bytes < `ETH_MIN_FRAME) begin
                entry.status = STATUS_RUNT;
            end else if (corrupt) begin
                entry.status = STATUS_CRC_ERR;
            end else begin
                entry.status = STATUS_OK;
            end
            exp_q.push_back(entry);
            frames_expected++;
        end

        for (int i = 0; i < pre_len; i++) begin
            drive_byte(`ETH_PREAMBLE_BYTE);
        end
        drive_byte(`ETH_SFD_BYTE);
        for (int i = 0; i < n_bytes; i++) begin
            drive_byte(bytes[i]);
        end
        @(posedge clk);
        rx_dv   <= 1'b0;
        rx_data <= 8'h00;
        repeat (GAP_CYCLES - 1) @(posedge clk);
    endtask

    // Expected entry stays put until the cycle after frame_done has been checked
    always @(negedge clk) begin
        if (done_prev && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
            frames_checked++;
        end
        done_prev = frame_done;
        exp_valid = (exp_q.size() > 0);
        if (exp_valid) begin
            exp_name      = exp_q[0].name;
            exp_dest      = exp_q[0].dest;
            exp_src       = exp_q[0].src;
            exp_type_len  = exp_q[0].type_len;
            exp_is_length = exp_q[0].is_length;
            exp_length    = exp_q[0].length;
            exp_status    = exp_q[0].status;
        end
    end

    reset_values: assert property (@(posedge clk)
        $fell(reset) |-> (!frame_done && rx_state == IDLE && frame_status == STATUS_OK))
        else report_failure("outputs not at their reset values after reset");

    done_expected: assert property (@(posedge clk) disable iff (reset)
        frame_done |-> exp_valid)
        else report_failure("frame_done fired with no frame expected");

    status_match: assert property (@(posedge clk) disable iff (reset)
        frame_done |-> frame_status == exp_status)
        else report_mismatch("frame_status", 64'(exp_status), 64'(frame_status));

    length_match: assert property (@(posedge clk) disable iff (reset)
        frame_done |-> frame_length == exp_length)
        else report_mismatch("frame_length", 64'(exp_length), 64'(frame_length));

    dest_match: assert property (@(posedge clk) disable iff (reset)
        frame_done |-> dest_mac == exp_dest)
        else report_mismatch("dest_mac", 64'(exp_dest), 64'(dest_mac));

    src_match: assert property (@(posedge clk) disable iff (reset)
        frame_done |-> src_mac == exp_src)
        else report_mismatch("src_mac", 64'(exp_src), 64'(src_mac));

    type_len_match: assert property (@(posedge clk) disable iff (reset)
        frame_done |-> type_len == exp_type_len)
        else report_mismatch("type_len", 64'(exp_type_len), 64'(type_len));

    is_length_match: assert property (@(posedge clk) disable iff (reset)
        frame_done |-> len_is_length == exp_is_length)
        else report_mismatch("len_is_length", 64'(exp_is_length), 64'(len_is_length));

    // Third preamble byte shows up on preamble_detected six cycles after rx_dv rises
    preamble_seen: assert property (@(posedge clk) disable iff (reset)
        $rose(rx_dv) |-> ##6 preamble_detected)
        else report_failure("preamble_detected did not rise during the preamble");

    gap_clear: assert property (@(posedge clk) disable iff (reset)
        !rx_dv |=> !preamble_detected)
        else report_failure("preamble_detected high while the line is idle");

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: frames still outstanding after %0d cycles", WATCHDOG_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int          rand_len;
        logic [15:0] rand_tl;
        void'($urandom(56));
        reset   = 1'b1;
        rx_data = 8'h00;
        rx_dv   = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);

        rand_len = `ETH_MIN_FRAME + int'($urandom % 32'd1455);
        rand_tl  = 16'($urandom % 32'd1501);

        send_frame("good_min", 7, 64, 16'h0800, 1'b0);
        send_frame("good_random", 7, rand_len, rand_tl, 1'b0);
        send_frame("length_1500", 7, 80, 16'd1500, 1'b0);
        send_frame("crc_error", 7, 128, 16'h86DD, 1'b1);
        send_frame("runt", 7, 40, 16'h0800, 1'b0);
        send_frame("giant", 7, 1530, 16'h0800, 1'b0);
        send_frame("short_preamble", 4, 64, 16'h0800, 1'b0);
        send_frame("recovery", 7, 72, 16'd46, 1'b0);

        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);

        $display("Frames checked: %0d of %0d, errors: %0d",
                 frames_checked, frames_expected, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+src
src/eth_frame_pkg.sv
src/eth_rx_status_pkg.sv
src/eth_preamble_detector.sv
src/eth_rx_fsm.sv
src/eth_byte_counter.sv
src/eth_header_parser.sv
src/eth_crc32_checker.sv
src/eth_rx_top.sv
tb/eth_rx_tb.sv

// ==== Makefile ====
# Verilator build and run for the Ethernet receive front end

VERILATOR ?= verilator
TOP       ?= eth_rx_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(FILELIST) $(wildcard src/*.sv src/*.svh tb/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: run

build: $(BIN)

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) 2>&1 | tee $(LOG)
	@$(MAKE) --no-print-directory check LOG=$(LOG)

check:
	@grep -q "SIMULATION PASSED" $(LOG) || { echo "No pass result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
